//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= frame_top_tb
FILELIST  ?= frame_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Pass only if the pass line shows up in the simulation output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- frame_top.f
+incdir+src
src/host_pkg.sv
src/mem_pkg.sv
src/region_decoder.sv
src/bank_port.sv
src/bank_arbiter.sv
src/rom_store.sv
src/rom_loader.sv
src/frame_top.sv
sim/frame_top_tb.sv

//--- sim/frame_top_tb.sv
// ROM subsystem testbench
// Loads words over APB, reads them back through the game port and checks
// data, bank tags and latency against a reference memory

`timescale 1ns/1ps
`default_nettype none
`include "frame_config.svh"

module frame_top_tb;

    localparam int ADDR_W     = `FRAME_ADDR_W;
    localparam int DATA_W     = `FRAME_DATA_W;
    localparam int BANKS      = `FRAME_BANKS;
    localparam int BANK_W     = `FRAME_BANK_W;
    localparam int CLK_PERIOD = 40;
    localparam int BLOCK      = 16;
    localparam int LOAD_WORDS = BANKS * BLOCK;
    localparam int RAND_READS = 200;
    localparam int TRANS      = 2 * LOAD_WORDS + RAND_READS + 32;

    logic               sample;
    logic               reset;
    host_pkg::apb_req_t apb_req;
    host_pkg::apb_rsp_t apb_rsp;
    logic               downloading;
    logic               game_valid;
    mem_pkg::game_req_t game_req;
    logic               game_ready;
    logic               rsp_valid;
    mem_pkg::rsp_t      rsp;

    integer            seed;
    int                errors;
    int                err_mark;
    int                test_num;
    int                cycle;
    int                accept_count;
    int                resp_count;
    logic              check_lat;
    logic [31:0]       rdata;
    logic              err;
    logic [DATA_W-1:0] ref_mem [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0] ref_ptr;
    logic [ADDR_W-1:0] loaded_addr [0:LOAD_WORDS-1];
    logic [ADDR_W-1:0] exp_addr [BANKS][$];
    int                exp_cyc [BANKS][$];

    frame_top i_dut (
        .sample      ( sample      ),
        .reset       ( reset       ),
        .apb_req     ( apb_req     ),
        .apb_rsp     ( apb_rsp     ),
        .downloading ( downloading ),
        .game_valid  ( game_valid  ),
        .game_req    ( game_req    ),
        .game_ready  ( game_ready  ),
        .rsp_valid   ( rsp_valid   ),
        .rsp         ( rsp         )
    );

    always #(CLK_PERIOD / 2) sample = ~sample;

    always @(posedge sample) begin
        cycle <= cycle + 1;
    end

    // Expected word is whatever the host last wrote at that address
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return ref_mem[addr];
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int b = 0; b < BANKS; b++) begin
            n += exp_addr[b].size();
        end
        return n;
    endfunction

    task automatic step();
        @(posedge sample);
        #1;
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("ERR %0t %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s done with %0d errors", test_num, name, errors - err_mark);
        err_mark = errors;
    endtask

    // Setup cycle, then access phase until pready
    task automatic apb_access(input logic write, input logic [3:0] off, input logic [31:0] wdata,
                              output logic [31:0] rd, output logic slverr);
        int waits;
        step();
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: off, pwdata: wdata};
        step();
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge sample);
        while (apb_rsp.pready !== 1'b1 && waits < 16) begin
            waits++;
            @(negedge sample);
        end
        if (apb_rsp.pready !== 1'b1) begin
            $display("APB access to offset %h never saw pready", off);
            errors++;
        end
        rd = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        step();
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [3:0] off, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        slverr;
        apb_access(1'b1, off, wdata, rd, slverr);
        if (slverr !== 1'b0) mismatch("pslverr", 32'(slverr), 32'd0);
        if (off == host_pkg::ADDR_OFF) ref_ptr = wdata[ADDR_W-1:0];
        if (off == host_pkg::DATA_OFF) begin
            ref_mem[ref_ptr] = wdata[DATA_W-1:0];
            ref_ptr = ref_ptr + 1'b1;
        end
    endtask

    task automatic check_reg(input logic [3:0] off, input logic [31:0] want, input string name);
        logic [31:0] rd;
        logic        slverr;
        apb_access(1'b0, off, 32'd0, rd, slverr);
        if (rd !== want) mismatch(name, rd, want);
    endtask

    task automatic record_accept(input logic [ADDR_W-1:0] addr);
        exp_addr[addr[ADDR_W-1 -: BANK_W]].push_back(addr);
        exp_cyc[addr[ADDR_W-1 -: BANK_W]].push_back(cycle);
        accept_count++;
    endtask

    task automatic wait_drain();
        int waits;
        waits = 0;
        while (outstanding() != 0 && waits < 64) begin
            waits++;
            @(negedge sample);
        end
        if (outstanding() != 0) begin
            $display("%0d game reads never got a response", outstanding());
            errors++;
        end
    endtask

    task automatic game_read_one(input logic [ADDR_W-1:0] addr);
        int waits;
        step();
        game_valid = 1'b1;
        game_req.addr = addr;
        waits = 0;
        @(negedge sample);
        while (game_ready !== 1'b1 && waits < 20) begin
            waits++;
            @(negedge sample);
        end
        if (game_ready === 1'b1) begin
            record_accept(addr);
        end else begin
            $display("Game read of %h was never accepted", addr);
            errors++;
        end
        step();
        game_valid = 1'b0;
        wait_drain();
    endtask

    // New address after every accepted request, valid never drops
    task automatic random_reads();
        int   accepted;
        int   idx;
        logic took;
        accepted = 0;
        step();
        idx = $unsigned($random(seed)) % LOAD_WORDS;
        game_valid = 1'b1;
        game_req.addr = loaded_addr[idx];
        while (accepted < RAND_READS) begin
            @(negedge sample);
            took = game_ready;
            if (took) begin
                record_accept(game_req.addr);
                accepted++;
            end
            step();
            if (took && accepted == RAND_READS) begin
                game_valid = 1'b0;
            end else if (took) begin
                idx = $unsigned($random(seed)) % LOAD_WORDS;
                game_req.addr = loaded_addr[idx];
            end
        end
        wait_drain();
    endtask

    // Response checker, pops the queue of the tagged bank
    always @(negedge sample) begin : compare_rsp
        logic [ADDR_W-1:0] a;
        int                c;
        if (!reset && rsp_valid === 1'b1) begin
            resp_count++;
            if (exp_addr[rsp.tag].size() == 0) begin
                $display("Response at %0t for bank %0d with no read outstanding", $time, rsp.tag);
                errors++;
            end else begin
                a = exp_addr[rsp.tag].pop_front();
                c = exp_cyc[rsp.tag].pop_front();
                if (rsp.data !== expected_word(a)) begin
                    mismatch("rsp.data", 32'(rsp.data), 32'(expected_word(a)));
                end
                if (check_lat && cycle - c != 3) mismatch("latency", cycle - c, 32'd3);
            end
        end
    end

    always @(negedge sample) begin
        if (!reset && downloading === 1'b1 && game_ready === 1'b1) begin
            $display("Game request accepted at %0t while downloading", $time);
            errors++;
        end
    end

    initial begin
        #((TRANS * 20 + 200) * CLK_PERIOD);
        $display("Run stopped by the watchdog before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 32'hf6f0_7ee4;
        sample = 1'b0;
        reset = 1'b1;
        apb_req = '0;
        game_valid = 1'b0;
        game_req = '0;
        errors = 0;
        err_mark = 0;
        test_num = 0;
        cycle = 0;
        accept_count = 0;
        resp_count = 0;
        check_lat = 1'b0;
        ref_ptr = '0;
        repeat (5) @(posedge sample);
        #1;
        reset = 1'b0;

        @(negedge sample);
        if (rsp_valid !== 1'b0) mismatch("rsp_valid", 32'(rsp_valid), 32'd0);
        if (game_ready !== 1'b0) mismatch("game_ready", 32'(game_ready), 32'd0);
        if (apb_rsp.pready !== 1'b0) mismatch("pready", 32'(apb_rsp.pready), 32'd0);
        if (downloading !== 1'b0) mismatch("downloading", 32'(downloading), 32'd0);
        check_reg(host_pkg::CTRL_OFF, 32'd0, "CTRL");
        check_reg(host_pkg::ADDR_OFF, 32'd0, "ADDR");
        check_reg(host_pkg::STATUS_OFF, 32'd0, "STATUS");
        end_test("reset state");

        // One block per bank, game side held off meanwhile
        apb_write(host_pkg::CTRL_OFF, 32'd1);
        game_valid = 1'b1;
        for (int b = 0; b < BANKS; b++) begin
            apb_write(host_pkg::ADDR_OFF, 32'(b * 1024 + 64));
            for (int w = 0; w < BLOCK; w++) begin
                loaded_addr[b * BLOCK + w] = ref_ptr;
                apb_write(host_pkg::DATA_OFF, $random(seed));
            end
            check_reg(host_pkg::ADDR_OFF, 32'(b * 1024 + 64 + BLOCK), "ADDR");
        end
        check_reg(host_pkg::STATUS_OFF, 32'd0, "STATUS");
        game_valid = 1'b0;
        end_test("download");

        apb_write(host_pkg::CTRL_OFF, 32'd0);
        check_lat = 1'b1;
        for (int n = 0; n < LOAD_WORDS; n++) begin
            game_read_one(loaded_addr[n]);
        end
        check_lat = 1'b0;
        end_test("single reads");

        random_reads();
        if (resp_count != accept_count) mismatch("response count", resp_count, accept_count);
        end_test("random reads");

        check_reg(host_pkg::ADDR_OFF, 32'(3 * 1024 + 64 + BLOCK), "ADDR");
        apb_access(1'b0, 4'h2, 32'd0, rdata, err);
        if (err !== 1'b1) begin
            $display("Read of unknown offset 2 did not raise pslverr");
            errors++;
        end
        check_reg(host_pkg::CTRL_OFF, 32'd0, "CTRL");
        check_reg(host_pkg::ADDR_OFF, 32'(3 * 1024 + 64 + BLOCK), "ADDR");
        check_reg(host_pkg::STATUS_OFF, 32'd0, "STATUS");
        end_test("unknown offset");

        $display("tests %0d requests %0d responses %0d errors %0d",
                 test_num, accept_count, resp_count, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/bank_arbiter.sv
// Bank arbiter
// Loader writes first, then round robin over full bank slots
// Each read is tagged with its bank for the response path

`timescale 1ns/1ps
`default_nettype none
`include "frame_config.svh"

module bank_arbiter (
    input  logic                                        sample,
    input  logic                                        reset,
    input  logic [`FRAME_BANKS-1:0]                     full,
    input  mem_pkg::bank_req_t [`FRAME_BANKS-1:0]       pend_req,
    input  logic                                        ld_valid,
    input  mem_pkg::store_cmd_t                         ld_cmd,
    output logic [`FRAME_BANKS-1:0]                     grant,
    output logic                                        ld_ready,
    output logic                                        cmd_valid,
    output mem_pkg::store_cmd_t                         store_cmd
);

    localparam int BANKS  = `FRAME_BANKS;
    localparam int BANK_W = `FRAME_BANK_W;

    logic [BANK_W-1:0] rr_ptr;
    logic [BANK_W-1:0] gnt_idx;
    logic              gnt_any;

    // Search starts at rr_ptr and wraps
    always_comb begin
        logic [BANK_W-1:0] idx;

        gnt_any = 1'b0;
        gnt_idx = '0;
        for (int k = 0; k < BANKS; k++) begin
            idx = rr_ptr + BANK_W'(k);
            if (!gnt_any && full[idx]) begin
                gnt_any = 1'b1;
                gnt_idx = idx;
            end
        end
        // Loader write takes this cycle
        if (ld_valid) begin
            gnt_any = 1'b0;
        end
    end

    always_comb begin
        grant = '0;
        if (gnt_any) begin
            grant[gnt_idx] = 1'b1;
        end
    end

    // Next search begins just after the bank last granted
    always_ff @(posedge sample) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (gnt_any) begin
            rr_ptr <= gnt_idx + 1'b1;
        end
    end

    assign ld_ready  = ld_valid;
    assign cmd_valid = ld_valid || gnt_any;

    always_comb begin
        if (ld_valid) begin
            store_cmd = ld_cmd;
        end else begin
            store_cmd.write = 1'b0;
            store_cmd.addr  = pend_req[gnt_idx].addr;
            store_cmd.data  = '0;
            store_cmd.tag   = gnt_idx;
        end
    end

    a_grant_onehot : assert property (
        @(posedge sample) disable iff (reset) $onehot0(grant)
    ) else $error("bank_arbiter: grant not one-hot");

endmodule

`default_nettype wire

//--- src/bank_port.sv
// Bank port
// One-entry slot holding a pending read until the arbiter grants it

`timescale 1ns/1ps
`default_nettype none

module bank_port (
    input  logic               sample,
    input  logic               reset,
    input  logic               load_valid,
    input  mem_pkg::bank_req_t load_req,
    input  logic               grant,
    output logic               full,
    output mem_pkg::bank_req_t pend_req
);

    // Slot state, a load wins over a grant so the slot refills
    always_ff @(posedge sample) begin
        if (reset) begin
            full <= 1'b0;
        end else if (load_valid) begin
            full <= 1'b1;
        end else if (grant) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge sample) begin
        if (load_valid) begin
            pend_req <= load_req;
        end
    end

    // Grant only ever goes to a slot that holds a read
    a_grant_full : assert property (
        @(posedge sample) disable iff (reset) grant |-> full
    ) else $error("bank_port: grant on an empty slot");

    a_no_overwrite : assert property (
        @(posedge sample) disable iff (reset) load_valid |-> (!full || grant)
    ) else $error("bank_port: load into a full slot");

endmodule

`default_nettype wire

//--- src/frame_config.svh
// Frame configuration
// Bank count, word widths and store read latency for the ROM subsystem

`ifndef FRAME_CONFIG_SVH
`define FRAME_CONFIG_SVH

// Number of game bank ports
`define FRAME_BANKS     4

// Bits of the bank index, also the response tag width
`define FRAME_BANK_W    2

// Word address for the game side and the store
`define FRAME_ADDR_W    12

// Data word
`define FRAME_DATA_W    16

// Cycles from a store read command to its response
`define FRAME_READ_LAT  2

`endif

//--- src/frame_top.sv
// ROM subsystem top
// Host loader, region decoder, four bank ports, arbiter and ROM store

`timescale 1ns/1ps
`default_nettype none
`include "frame_config.svh"

module frame_top (
    input  logic               sample,
    input  logic               reset,
    input  host_pkg::apb_req_t apb_req,
    output host_pkg::apb_rsp_t apb_rsp,
    output logic               downloading,
    input  logic               game_valid,
    input  mem_pkg::game_req_t game_req,
    output logic               game_ready,
    output logic               rsp_valid,
    output mem_pkg::rsp_t      rsp
);

    localparam int BANKS = `FRAME_BANKS;

    logic                           ld_valid;
    logic                           ld_ready;
    mem_pkg::store_cmd_t            ld_cmd;
    logic [BANKS-1:0]               load_valid;
    mem_pkg::bank_req_t             load_req;
    logic [BANKS-1:0]               full;
    logic [BANKS-1:0]               grant;
    mem_pkg::bank_req_t [BANKS-1:0] pend_req;
    logic                           cmd_valid;
    mem_pkg::store_cmd_t            store_cmd;

    rom_loader i_loader (
        .sample      ( sample      ),
        .reset       ( reset       ),
        .apb_req     ( apb_req     ),
        .ld_ready    ( ld_ready    ),
        .apb_rsp     ( apb_rsp     ),
        .downloading ( downloading ),
        .ld_valid    ( ld_valid    ),
        .ld_cmd      ( ld_cmd      )
    );

    region_decoder i_decoder (
        .sample      ( sample      ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .game_valid  ( game_valid  ),
        .game_req    ( game_req    ),
        .full        ( full        ),
        .game_ready  ( game_ready  ),
        .load_valid  ( load_valid  ),
        .load_req    ( load_req    )
    );

    // Identical slots, one per bank
    for (genvar i = 0; i < BANKS; i++) begin : g_bank
        bank_port i_bank_port (
            .sample     ( sample        ),
            .reset      ( reset         ),
            .load_valid ( load_valid[i] ),
            .load_req   ( load_req      ),
            .grant      ( grant[i]      ),
            .full       ( full[i]       ),
            .pend_req   ( pend_req[i]   )
        );
    end

    bank_arbiter i_arbiter (
        .sample    ( sample    ),
        .reset     ( reset     ),
        .full      ( full      ),
        .pend_req  ( pend_req  ),
        .ld_valid  ( ld_valid  ),
        .ld_cmd    ( ld_cmd    ),
        .grant     ( grant     ),
        .ld_ready  ( ld_ready  ),
        .cmd_valid ( cmd_valid ),
        .store_cmd ( store_cmd )
    );

    rom_store i_store (
        .sample    ( sample    ),
        .reset     ( reset     ),
        .cmd_valid ( cmd_valid ),
        .store_cmd ( store_cmd ),
        .rsp_valid ( rsp_valid ),
        .rsp       ( rsp       )
    );

endmodule

`default_nettype wire

//--- src/host_pkg.sv
// Host-side types
// APB request and response bundles and the loader register map

`default_nettype none

package host_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // Loader register offsets
    localparam logic [3:0] CTRL_OFF   = 4'h0;  // bit 0 downloading
    localparam logic [3:0] ADDR_OFF   = 4'h4;
    localparam logic [3:0] DATA_OFF   = 4'h8;
    localparam logic [3:0] STATUS_OFF = 4'hC;  // bit 0 write pending

endpackage

`default_nettype wire

//--- src/mem_pkg.sv
// Memory-side types
// Game requests, bank slots, store commands and tagged responses

`default_nettype none
`include "frame_config.svh"

package mem_pkg;

    // Word address from the game
    typedef struct packed {
        logic [`FRAME_ADDR_W-1:0] addr;
    } game_req_t;

    // Read held in a bank slot
    typedef struct packed {
        logic [`FRAME_ADDR_W-1:0] addr;
    } bank_req_t;

    // One store access, either a loader write or a tagged bank read
    typedef struct packed {
        logic                     write;
        logic [`FRAME_ADDR_W-1:0] addr;
        logic [`FRAME_DATA_W-1:0] data;
        logic [`FRAME_BANK_W-1:0] tag;
    } store_cmd_t;

    typedef struct packed {
        logic [`FRAME_DATA_W-1:0] data;
        logic [`FRAME_BANK_W-1:0] tag;
    } rsp_t;

endpackage

`default_nettype wire

//--- src/region_decoder.sv
// Region decoder
// Sends each game read to the bank port picked by its top address bits

`timescale 1ns/1ps
`default_nettype none
`include "frame_config.svh"

module region_decoder (
    input  logic                    sample,
    input  logic                    reset,
    input  logic                    downloading,
    input  logic                    game_valid,
    input  mem_pkg::game_req_t      game_req,
    input  logic [`FRAME_BANKS-1:0] full,
    output logic                    game_ready,
    output logic [`FRAME_BANKS-1:0] load_valid,
    output mem_pkg::bank_req_t      load_req
);

    localparam int BANKS  = `FRAME_BANKS;
    localparam int ADDR_W = `FRAME_ADDR_W;
    localparam int BANK_W = `FRAME_BANK_W;

    logic [BANK_W-1:0] sel;

    assign sel = game_req.addr[ADDR_W-1 -: BANK_W];

    // Game side waits during a download or while its bank slot is busy
    assign game_ready = game_valid && !downloading && !full[sel];

    always_comb begin
        for (int i = 0; i < BANKS; i++) begin
            load_valid[i] = game_ready && (sel == BANK_W'(i));
        end
    end

    // Full address goes along, the store needs the bank bits too
    assign load_req.addr = game_req.addr;

    a_load_onehot : assert property (
        @(posedge sample) disable iff (reset) $onehot0(load_valid)
    ) else $error("region_decoder: more than one bank loaded");

endmodule

`default_nettype wire

//--- src/rom_loader.sv
// ROM loader
// APB register block, each DATA write becomes one store write
// and the load address steps by one once the write is taken

`timescale 1ns/1ps
`default_nettype none
`include "frame_config.svh"

module rom_loader (
    input  logic                sample,
    input  logic                reset,
    input  host_pkg::apb_req_t  apb_req,
    input  logic                ld_ready,
    output host_pkg::apb_rsp_t  apb_rsp,
    output logic                downloading,
    output logic                ld_valid,
    output mem_pkg::store_cmd_t ld_cmd
);

    localparam int ADDR_W = `FRAME_ADDR_W;
    localparam int DATA_W = `FRAME_DATA_W;

    logic              access;
    logic              known;
    logic              dl_q;
    logic [ADDR_W-1:0] addr_q;

    assign access = apb_req.psel && apb_req.penable;

    // Store write lasts for the whole DATA access phase
    assign ld_valid = access && apb_req.pwrite && (apb_req.paddr == host_pkg::DATA_OFF);

    assign ld_cmd.write = 1'b1;
    assign ld_cmd.addr  = addr_q;
    assign ld_cmd.data  = apb_req.pwdata[DATA_W-1:0];
    assign ld_cmd.tag   = '0;

    // Read mux and offset check
    always_comb begin
        apb_rsp.prdata = '0;
        known          = 1'b1;
        case (apb_req.paddr)
            host_pkg::CTRL_OFF:   apb_rsp.prdata[0] = dl_q;
            host_pkg::ADDR_OFF:   apb_rsp.prdata[ADDR_W-1:0] = addr_q;
            host_pkg::DATA_OFF:   apb_rsp.prdata = '0;
            host_pkg::STATUS_OFF: apb_rsp.prdata[0] = ld_valid;
            default:              known = 1'b0;
        endcase
    end

    // DATA writes wait on the arbiter, the rest finish at once
    assign apb_rsp.pready  = access && (!ld_valid || ld_ready);
    assign apb_rsp.pslverr = access && !known;

    always_ff @(posedge sample) begin
        if (reset) begin
            dl_q   <= 1'b0;
            addr_q <= '0;
        end else if (access && apb_req.pwrite) begin
            case (apb_req.paddr)
                host_pkg::CTRL_OFF: dl_q <= apb_req.pwdata[0];
                host_pkg::ADDR_OFF: addr_q <= apb_req.pwdata[ADDR_W-1:0];
                host_pkg::DATA_OFF: begin
                    if (ld_ready) begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign downloading = dl_q;

endmodule

`default_nettype wire

//--- src/rom_store.sv
// ROM store
// Word array written by the loader, read through a fixed-latency pipeline
// Reads from several banks may be in flight together

`timescale 1ns/1ps
`default_nettype none
`include "frame_config.svh"

module rom_store (
    input  logic                sample,
    input  logic                reset,
    input  logic                cmd_valid,
    input  mem_pkg::store_cmd_t store_cmd,
    output logic                rsp_valid,
    output mem_pkg::rsp_t       rsp
);

    localparam int ADDR_W = `FRAME_ADDR_W;
    localparam int DATA_W = `FRAME_DATA_W;
    localparam int LAT    = `FRAME_READ_LAT;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [DATA_W-1:0]             mem [0:DEPTH-1];
    logic [LAT-1:0]                vld_q;
    mem_pkg::rsp_t [LAT-1:0]       rsp_q;

    always_ff @(posedge sample) begin
        if (cmd_valid && store_cmd.write) begin
            mem[store_cmd.addr] <= store_cmd.data;
        end
    end

    // Valid chain
    always_ff @(posedge sample) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= cmd_valid && !store_cmd.write;
            for (int s = 1; s < LAT; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    // Data and tag chain, first stage is the array read
    always_ff @(posedge sample) begin
        rsp_q[0].data <= mem[store_cmd.addr];
        rsp_q[0].tag  <= store_cmd.tag;
        for (int s = 1; s < LAT; s++) begin
            rsp_q[s] <= rsp_q[s-1];
        end
    end

    assign rsp_valid = vld_q[LAT-1];
    assign rsp       = rsp_q[LAT-1];

endmodule

`default_nettype wire
